// File: build.f
design/csc_pkg.sv
design/csc_term_if.sv
design/csc_mul.sv
design/csc_add.sv
design/csc_channel.sv
design/csc_rgb2ycbcr.sv
bench/csc_clk_gen.sv
bench/tb_csc.sv

// File: run_sim.sh
#!/bin/sh
# compile with verilator, run, then look for the failure line in the log.
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module tb_csc -f build.f > build.log 2>&1 &&
./obj_dir/Vtb_csc > sim.log 2>&1 &&
! grep -q "Regression failed" sim.log &&
echo "simulation ok, see sim.log" ||
{ echo "simulation or build failed, see build.log and sim.log"; exit 1; }

// File: bench/tb_csc.sv
`timescale 1ns/1ns

module tb_csc;

  localparam int n_rows         = 40;
  localparam int n_fixed        = 8;
  localparam int latency        = 6;
  localparam int rst_cycles     = 10;
  localparam int timeout_cycles = rst_cycles + n_rows + latency + 20;
  localparam int scale          = 4096;

  // offsets chosen so that both clip limits are reachable.
  localparam logic [7:0] y_off  = 8'd64;
  localparam logic [7:0] cr_off = 8'd0;

  logic       clk;
  logic       rst_n;
  logic [7:0] r;
  logic [7:0] g;
  logic [7:0] b;
  logic       de_in;
  logic       hsync_in;
  logic       vsync_in;
  logic [7:0] y;
  logic [7:0] cb;
  logic [7:0] cr;
  logic       de_out;
  logic       hsync_out;
  logic       vsync_out;

  logic [7:0] r_tab  [n_rows];
  logic [7:0] g_tab  [n_rows];
  logic [7:0] b_tab  [n_rows];
  logic       de_tab [n_rows];
  logic       hs_tab [n_rows];
  logic       vs_tab [n_rows];
  logic [7:0] y_exp  [n_rows];
  logic [7:0] cb_exp [n_rows];
  logic [7:0] cr_exp [n_rows];

  integer seed;
  int     errors;
  int     checks;
  int     cycle_count = 0;

  csc_clk_gen #(
    .HALF_PERIOD (5),
    .RST_CYCLES  (rst_cycles)
  ) clk_gen0 (
    .clk   (clk),
    .rst_n (rst_n)
  );

  csc_rgb2ycbcr #(
    .Y_OFF  (y_off),
    .CR_OFF (cr_off)
  ) dut0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .r         (r),
    .g         (g),
    .b         (b),
    .de_in     (de_in),
    .hsync_in  (hsync_in),
    .vsync_in  (vsync_in),
    .y         (y),
    .cb        (cb),
    .cr        (cr),
    .de_out    (de_out),
    .hsync_out (hsync_out),
    .vsync_out (vsync_out)
  );

  // signed product of a pixel and a sign-magnitude coefficient.
  function automatic int scaled_term(input logic [16:0] coef, input logic [7:0] pix);
    int mag;
    mag = int'(coef[15:0]) * int'(pix);
    if (coef[16]) begin
      return -mag;
    end
    return mag;
  endfunction

  // weighted sum plus offset, then clipped to one byte.
  function automatic logic [7:0] expected_component(
    input logic [16:0] c_r,
    input logic [16:0] c_g,
    input logic [16:0] c_b,
    input logic [7:0]  off,
    input logic [7:0]  pr,
    input logic [7:0]  pg,
    input logic [7:0]  pb
  );
    int sum;
    int whole;
    sum = scaled_term(c_r, pr) + scaled_term(c_g, pg) + scaled_term(c_b, pb);
    sum = sum + int'(off) * scale;
    if (sum < 0) begin
      return 8'h00;
    end
    whole = sum / scale;
    if (whole > 255) begin
      return 8'hff;
    end
    return whole[7:0];
  endfunction

  task automatic set_row(input int idx, input logic [7:0] pr, input logic [7:0] pg,
                         input logic [7:0] pb, input logic [2:0] sync);
    r_tab[idx]  = pr;
    g_tab[idx]  = pg;
    b_tab[idx]  = pb;
    hs_tab[idx] = sync[2];
    vs_tab[idx] = sync[1];
    de_tab[idx] = sync[0];
    y_exp[idx]  = expected_component(csc_pkg::Y_R, csc_pkg::Y_G, csc_pkg::Y_B,
                                     y_off, pr, pg, pb);
    cb_exp[idx] = expected_component(csc_pkg::CB_R, csc_pkg::CB_G, csc_pkg::CB_B,
                                     csc_pkg::CB_OFF, pr, pg, pb);
    cr_exp[idx] = expected_component(csc_pkg::CR_R, csc_pkg::CR_G, csc_pkg::CR_B,
                                     cr_off, pr, pg, pb);
  endtask

  // sync column is {hsync, vsync, de}.
  task automatic fill_table();
    logic [31:0] word;
    set_row(0, 8'h00, 8'h00, 8'h00, 3'b001);
    set_row(1, 8'hff, 8'hff, 8'hff, 3'b101);
    set_row(2, 8'hff, 8'h00, 8'h00, 3'b011);
    set_row(3, 8'h00, 8'hff, 8'h00, 3'b111);
    set_row(4, 8'h00, 8'h00, 8'hff, 3'b100);
    set_row(5, 8'h80, 8'h80, 8'h80, 3'b010);
    set_row(6, 8'hff, 8'h00, 8'hff, 3'b001);
    set_row(7, 8'h00, 8'hff, 8'hff, 3'b000);
    for (int i = n_fixed; i < n_rows; i++) begin
      word = $random(seed);
      set_row(i, word[7:0], word[15:8], word[23:16], word[26:24]);
    end
  endtask

  task automatic drive_row(input int idx);
    r        = r_tab[idx];
    g        = g_tab[idx];
    b        = b_tab[idx];
    de_in    = de_tab[idx];
    hsync_in = hs_tab[idx];
    vsync_in = vs_tab[idx];
  endtask

  task automatic drive_idle();
    r        = 8'h00;
    g        = 8'h00;
    b        = 8'h00;
    de_in    = 1'b0;
    hsync_in = 1'b0;
    vsync_in = 1'b0;
  endtask

  task automatic check_sync_idle();
    checks++;
    if ({hsync_out, vsync_out, de_out} !== 3'b000) begin
      $display("CHECK FAILED at %0t: sync outputs %03b during reset flush, expected 000",
               $time, {hsync_out, vsync_out, de_out});
      errors++;
    end
  endtask

  task automatic check_row(input int idx);
    checks++;
    if (y !== y_exp[idx]) begin
      $display("CHECK FAILED at %0t: row %0d y is %02h, expected %02h",
               $time, idx, y, y_exp[idx]);
      errors++;
    end
    if (cb !== cb_exp[idx]) begin
      $display("CHECK FAILED at %0t: row %0d cb is %02h, expected %02h",
               $time, idx, cb, cb_exp[idx]);
      errors++;
    end
    if (cr !== cr_exp[idx]) begin
      $display("CHECK FAILED at %0t: row %0d cr is %02h, expected %02h",
               $time, idx, cr, cr_exp[idx]);
      errors++;
    end
    if ({hsync_out, vsync_out, de_out} !== {hs_tab[idx], vs_tab[idx], de_tab[idx]}) begin
      $display("CHECK FAILED at %0t: row %0d sync is %03b, expected %03b",
               $time, idx, {hsync_out, vsync_out, de_out},
               {hs_tab[idx], vs_tab[idx], de_tab[idx]});
      errors++;
    end
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
      $display("Regression failed");
      $finish;
    end
  end

  initial begin
    errors   = 0;
    checks   = 0;
    seed     = 32'he6af563c;
    r        = 8'h55;
    g        = 8'haa;
    b        = 8'h33;
    de_in    = 1'b1;
    hsync_in = 1'b1;
    vsync_in = 1'b1;
    fill_table();

    // the corner rows must really reach both clip limits.
    if (y_exp[1] !== 8'hff) begin
      $display("table problem: white does not reach the high clip of y");
      errors++;
    end
    if (cr_exp[3] !== 8'h00) begin
      $display("table problem: pure green does not reach the low clip of cr");
      errors++;
    end

    // sync inputs held high in reset must not reach the outputs.
    repeat (rst_cycles - 1) begin
      @(posedge clk);
      #1;
      check_sync_idle();
    end

    for (int c = 0; c < n_rows + latency; c++) begin
      @(posedge clk);
      #1;
      if (c < latency) begin
        check_sync_idle();
      end else begin
        check_row(c - latency);
      end
      if (c < n_rows) begin
        drive_row(c);
      end else begin
        drive_idle();
      end
    end

    $display("checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: bench/csc_clk_gen.sv
`timescale 1ns/1ns

module csc_clk_gen #(
  parameter int HALF_PERIOD = 5,
  parameter int RST_CYCLES  = 10
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // release just after the last reset edge.
  initial begin
    rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
  end

endmodule

// File: design/csc_rgb2ycbcr.sv
`timescale 1ns/1ns

module csc_rgb2ycbcr #(
  parameter logic [csc_pkg::coef_w-1:0] Y_R    = csc_pkg::Y_R,
  parameter logic [csc_pkg::coef_w-1:0] Y_G    = csc_pkg::Y_G,
  parameter logic [csc_pkg::coef_w-1:0] Y_B    = csc_pkg::Y_B,
  parameter logic [csc_pkg::coef_w-1:0] CB_R   = csc_pkg::CB_R,
  parameter logic [csc_pkg::coef_w-1:0] CB_G   = csc_pkg::CB_G,
  parameter logic [csc_pkg::coef_w-1:0] CB_B   = csc_pkg::CB_B,
  parameter logic [csc_pkg::coef_w-1:0] CR_R   = csc_pkg::CR_R,
  parameter logic [csc_pkg::coef_w-1:0] CR_G   = csc_pkg::CR_G,
  parameter logic [csc_pkg::coef_w-1:0] CR_B   = csc_pkg::CR_B,
  parameter logic [csc_pkg::pix_w-1:0]  Y_OFF  = csc_pkg::Y_OFF,
  parameter logic [csc_pkg::pix_w-1:0]  CB_OFF = csc_pkg::CB_OFF,
  parameter logic [csc_pkg::pix_w-1:0]  CR_OFF = csc_pkg::CR_OFF
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [csc_pkg::pix_w-1:0] r,
  input  logic [csc_pkg::pix_w-1:0] g,
  input  logic [csc_pkg::pix_w-1:0] b,
  input  logic                      de_in,
  input  logic                      hsync_in,
  input  logic                      vsync_in,
  output logic [csc_pkg::pix_w-1:0] y,
  output logic [csc_pkg::pix_w-1:0] cb,
  output logic [csc_pkg::pix_w-1:0] cr,
  output logic                      de_out,
  output logic                      hsync_out,
  output logic                      vsync_out
);

  // the y channel carries the full sync word.
  csc_channel #(
    .DELAY_DATA_WIDTH (csc_pkg::sync_w),
    .C_R              (Y_R),
    .C_G              (Y_G),
    .C_B              (Y_B),
    .OFFSET           (Y_OFF)
  ) chan_y (
    .clk       (clk),
    .rst_n     (rst_n),
    .r         (r),
    .g         (g),
    .b         (b),
    .ddata_in  ({hsync_in, vsync_in, de_in}),
    .data      (y),
    .ddata_out ({hsync_out, vsync_out, de_out})
  );

  csc_channel #(
    .DELAY_DATA_WIDTH (1),
    .C_R              (CB_R),
    .C_G              (CB_G),
    .C_B              (CB_B),
    .OFFSET           (CB_OFF)
  ) chan_cb (
    .clk       (clk),
    .rst_n     (rst_n),
    .r         (r),
    .g         (g),
    .b         (b),
    .ddata_in  (de_in),
    .data      (cb),
    .ddata_out ()
  );

  csc_channel #(
    .DELAY_DATA_WIDTH (1),
    .C_R              (CR_R),
    .C_G              (CR_G),
    .C_B              (CR_B),
    .OFFSET           (CR_OFF)
  ) chan_cr (
    .clk       (clk),
    .rst_n     (rst_n),
    .r         (r),
    .g         (g),
    .b         (b),
    .ddata_in  (de_in),
    .data      (cr),
    .ddata_out ()
  );

endmodule

// File: design/csc_channel.sv
`timescale 1ns/1ns

module csc_channel #(
  parameter int                         DELAY_DATA_WIDTH = 1,
  parameter logic [csc_pkg::coef_w-1:0] C_R              = '0,
  parameter logic [csc_pkg::coef_w-1:0] C_G              = '0,
  parameter logic [csc_pkg::coef_w-1:0] C_B              = '0,
  parameter logic [csc_pkg::pix_w-1:0]  OFFSET           = '0
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic [csc_pkg::pix_w-1:0]   r,
  input  logic [csc_pkg::pix_w-1:0]   g,
  input  logic [csc_pkg::pix_w-1:0]   b,
  input  logic [DELAY_DATA_WIDTH-1:0] ddata_in,
  output logic [csc_pkg::pix_w-1:0]   data,
  output logic [DELAY_DATA_WIDTH-1:0] ddata_out
);

  logic [DELAY_DATA_WIDTH-1:0] d1_ddata;
  logic [DELAY_DATA_WIDTH-1:0] d2_ddata;

  csc_term_if #(
    .DELAY_DATA_WIDTH (DELAY_DATA_WIDTH)
  ) terms_if ();

  csc_mul #(.COEF(C_R)) mul_r (
    .clk  (clk),
    .pix  (r),
    .prod (terms_if.term_1)
  );

  csc_mul #(.COEF(C_G)) mul_g (
    .clk  (clk),
    .pix  (g),
    .prod (terms_if.term_2)
  );

  csc_mul #(.COEF(C_B)) mul_b (
    .clk  (clk),
    .pix  (b),
    .prod (terms_if.term_3)
  );

  // two stages, same as the multipliers.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      d1_ddata <= '0;
      d2_ddata <= '0;
    end else begin
      d1_ddata <= ddata_in;
      d2_ddata <= d1_ddata;
    end
  end

  assign terms_if.ddata = d2_ddata;

  csc_add #(
    .DELAY_DATA_WIDTH (DELAY_DATA_WIDTH),
    .OFFSET           (OFFSET)
  ) add0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .terms     (terms_if.dst),
    .data_p    (data),
    .ddata_out (ddata_out)
  );

endmodule

// File: design/csc_add.sv
`timescale 1ns/1ns

module csc_add #(
  parameter int                        DELAY_DATA_WIDTH = 1,
  parameter logic [csc_pkg::pix_w-1:0] OFFSET           = '0
) (
  input  logic                        clk,
  input  logic                        rst_n,
  csc_term_if.dst                     terms,
  output logic [csc_pkg::pix_w-1:0]   data_p,
  output logic [DELAY_DATA_WIDTH-1:0] ddata_out
);

  localparam int TW = csc_pkg::term_w;
  localparam int HI = csc_pkg::frac_w + csc_pkg::pix_w;

  // offset as an integer with frac_w zero fraction bits.
  localparam logic [TW-1:0] OFF_TERM = {
    {(TW - HI){1'b0}}, OFFSET, {csc_pkg::frac_w{1'b0}}
  };

  logic [DELAY_DATA_WIDTH-1:0] p1_ddata;
  logic [DELAY_DATA_WIDTH-1:0] p2_ddata;
  logic [DELAY_DATA_WIDTH-1:0] p3_ddata;
  logic [TW-1:0]               p1_term_1;
  logic [TW-1:0]               p1_term_2;
  logic [TW-1:0]               p1_term_3;
  logic [TW-1:0]               p2_sum_0;
  logic [TW-1:0]               p2_sum_1;
  logic [TW-1:0]               p3_sum;

  // sign-magnitude to two's complement.
  function automatic logic [TW-1:0] sm_to_tc(input logic [TW-1:0] sm);
    logic [TW-1:0] mag;
    mag = {1'b0, sm[TW-2:0]};
    if (sm[TW-1]) begin
      return ~mag + 1'b1;
    end
    return mag;
  endfunction

  // sync word follows the data through all four stages.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      p1_ddata  <= '0;
      p2_ddata  <= '0;
      p3_ddata  <= '0;
      ddata_out <= '0;
    end else begin
      p1_ddata  <= terms.ddata;
      p2_ddata  <= p1_ddata;
      p3_ddata  <= p2_ddata;
      ddata_out <= p3_ddata;
    end
  end

  // stage 1.
  always_ff @(posedge clk) begin
    p1_term_1 <= sm_to_tc(terms.term_1);
    p1_term_2 <= sm_to_tc(terms.term_2);
    p1_term_3 <= sm_to_tc(terms.term_3);
  end

  // stage 2, pair sums.
  always_ff @(posedge clk) begin
    p2_sum_0 <= p1_term_1 + p1_term_2;
    p2_sum_1 <= p1_term_3 + OFF_TERM;
  end

  // stage 3.
  always_ff @(posedge clk) begin
    p3_sum <= p2_sum_0 + p2_sum_1;
  end

  // stage 4, clip to 0..255.
  always_ff @(posedge clk) begin
    if (p3_sum[TW-1]) begin
      data_p <= 8'h00;
    end else if (p3_sum[TW-2:HI] != '0) begin
      data_p <= 8'hff;
    end else begin
      data_p <= p3_sum[HI-1:csc_pkg::frac_w];
    end
  end

endmodule

// File: design/csc_mul.sv
`timescale 1ns/1ns

module csc_mul #(
  parameter logic [csc_pkg::coef_w-1:0] COEF = '0
) (
  input  logic                       clk,
  input  logic [csc_pkg::pix_w-1:0]  pix,
  output logic [csc_pkg::term_w-1:0] prod
);

  localparam int MAG_W = csc_pkg::coef_w - 1;

  logic [csc_pkg::pix_w-1:0]  p1_pix;
  logic [csc_pkg::term_w-2:0] mag_s;

  // unsigned pixel times coefficient magnitude.
  assign mag_s = p1_pix * COEF[MAG_W-1:0];

  // stage 1.
  always_ff @(posedge clk) begin
    p1_pix <= pix;
  end

  // stage 2, sign rides on top of the magnitude.
  always_ff @(posedge clk) begin
    prod <= {COEF[csc_pkg::coef_w-1], mag_s};
  end

endmodule

// File: design/csc_term_if.sv
`timescale 1ns/1ns

interface csc_term_if #(
  parameter int DELAY_DATA_WIDTH = 1
);

  // sign-magnitude products, one per colour input.
  logic [csc_pkg::term_w-1:0]  term_1;
  logic [csc_pkg::term_w-1:0]  term_2;
  logic [csc_pkg::term_w-1:0]  term_3;
  logic [DELAY_DATA_WIDTH-1:0] ddata;

  modport src (
    output term_1,
    output term_2,
    output term_3,
    output ddata
  );

  modport dst (
    input term_1,
    input term_2,
    input term_3,
    input ddata
  );

endinterface

// File: design/csc_pkg.sv
package csc_pkg;

  // word widths.
  parameter int pix_w  = 8;
  parameter int coef_w = 17;
  parameter int term_w = 25;
  parameter int frac_w = 12;
  parameter int sync_w = 3;

  // coefficients are sign-magnitude, magnitude scaled by 4096.
  // bit 16 is the sign.
  parameter logic [coef_w-1:0] Y_R  = {1'b0, 16'd1053};
  parameter logic [coef_w-1:0] Y_G  = {1'b0, 16'd2064};
  parameter logic [coef_w-1:0] Y_B  = {1'b0, 16'd401};

  parameter logic [coef_w-1:0] CB_R = {1'b1, 16'd606};
  parameter logic [coef_w-1:0] CB_G = {1'b1, 16'd1192};
  parameter logic [coef_w-1:0] CB_B = {1'b0, 16'd1798};

  parameter logic [coef_w-1:0] CR_R = {1'b0, 16'd1798};
  parameter logic [coef_w-1:0] CR_G = {1'b1, 16'd1507};
  parameter logic [coef_w-1:0] CR_B = {1'b1, 16'd291};

  // integer offsets, added after the products.
  parameter logic [pix_w-1:0] Y_OFF  = 8'd16;
  parameter logic [pix_w-1:0] CB_OFF = 8'd128;
  parameter logic [pix_w-1:0] CR_OFF = 8'd128;

endpackage
